/* periph.f */
common/periph_pkg.sv
common/reg_bus_if.sv
hw/wb_slave.sv
gpio/gpio_port.sv
timer/sys_timer.sv
timer/cycle_counter.sv
hw/irq_ctrl.sv
hw/periph_top.sv
testbench/periph_properties.sv
testbench/periph_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module periph_tb -f periph.f -o periph_sim \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/periph_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "All tests passed" && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

/* testbench/periph_tb.sv */
`timescale 1ns/1ps

module periph_tb;

    localparam int ACK_TIMEOUT = 20;
    localparam int IRQ_TIMEOUT = 40;

    logic                               clk;
    logic                               rst;
    logic                               wb_cyc;
    logic                               wb_stb;
    logic                               wb_we;
    periph_pkg::word_t                  wb_adr;
    periph_pkg::byte_sel_t              wb_sel;
    periph_pkg::word_t                  wb_wdata;
    logic                               wb_ack;
    periph_pkg::word_t                  wb_rdata;
    periph_pkg::word_t                  gpio_in;
    periph_pkg::word_t                  gpio_out;
    periph_pkg::word_t                  gpio_dir;
    logic [periph_pkg::NUM_EXT_IRQ-1:0] irq_lines;
    logic                               irq_ack;
    logic                               cpu_irq;
    periph_pkg::irq_id_t                irq_id;

    integer seed;
    int     edge_count;
    int     ack_edge;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;

    periph_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // rising edges since time zero
    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s did not complete in time", what);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic report_mismatch(input string what, input periph_pkg::word_t got,
                                   input periph_pkg::word_t exp);
        $display("FAIL %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
            total_errors += test_errors;
        end
        test_errors = 0;
    endtask

    // one transfer, called and returning on a falling edge
    task automatic bus_cycle(input logic we, input periph_pkg::reg_idx_t idx,
                             input periph_pkg::byte_sel_t sel, input periph_pkg::word_t wdata,
                             output periph_pkg::word_t rdata);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = {26'b0, idx, 2'b00};
        wb_sel   = sel;
        wb_wdata = wdata;
        @(negedge clk);
        while (!wb_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack) begin
            stop_on_timeout("bus transfer waiting for wb_ack");
        end else begin
            rdata    = wb_rdata;
            ack_edge = edge_count;
            wb_stb   = 1'b0;
            wb_we    = 1'b0;
        end
    endtask

    task automatic bus_write(input periph_pkg::reg_idx_t idx, input periph_pkg::byte_sel_t sel,
                             input periph_pkg::word_t data);
        periph_pkg::word_t discard;
        bus_cycle(1'b1, idx, sel, data, discard);
    endtask

    task automatic bus_read(input periph_pkg::reg_idx_t idx, output periph_pkg::word_t data);
        bus_cycle(1'b0, idx, 4'hf, '0, data);
    endtask

    task automatic wait_for_irq(output logic seen);
        int waited;
        waited = 0;
        while (!cpu_irq && waited < IRQ_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        seen = cpu_irq;
    endtask

    task automatic pulse_irq_ack();
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
    endtask

    // timer with max 0 reloads and flags on every cycle
    function automatic periph_pkg::word_t reset_value(input periph_pkg::reg_idx_t idx);
        if (idx == periph_pkg::REG_GPIO_DIR) begin
            return 32'hffff_ffff;
        end
        if (idx == periph_pkg::REG_TIMER_INTF) begin
            return 32'd1;
        end
        return '0;
    endfunction

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset_values();
        periph_pkg::word_t    data;
        periph_pkg::reg_idx_t idx;
        if (gpio_dir !== 32'hffff_ffff) report_mismatch("gpio_dir", gpio_dir, 32'hffff_ffff);
        if (gpio_out !== '0) report_mismatch("gpio_out", gpio_out, '0);
        if (cpu_irq !== 1'b0) report_mismatch("cpu_irq", {31'b0, cpu_irq}, '0);
        for (int i = 0; i < 16; i++) begin
            idx = i[3:0];
            bus_read(idx, data);
            if (data !== reset_value(idx)) begin
                report_mismatch($sformatf("register %0d", i), data, reset_value(idx));
            end
        end
    endtask

    task automatic test_gpio();
        periph_pkg::word_t data_wr;
        periph_pkg::word_t pins;
        periph_pkg::word_t data;
        periph_pkg::word_t exp;
        data_wr = $random(seed);
        pins    = $random(seed);
        // lower half inputs, upper half outputs
        bus_write(periph_pkg::REG_GPIO_DIR, 4'hf, 32'h0000_ffff);
        bus_write(periph_pkg::REG_GPIO_DATA, 4'hf, data_wr);
        repeat (4) @(negedge clk);
        exp = {data_wr[31:16], 16'h0};
        if (gpio_out !== exp) report_mismatch("gpio_out", gpio_out, exp);
        if (gpio_dir !== 32'h0000_ffff) report_mismatch("gpio_dir", gpio_dir, 32'h0000_ffff);
        gpio_in = pins;
        repeat (4) @(negedge clk);
        bus_read(periph_pkg::REG_GPIO_DATA, data);
        exp = {data_wr[31:16], pins[15:0]};
        if (data !== exp) report_mismatch("gpio data with inputs", data, exp);
        bus_write(periph_pkg::REG_GPIO_DATA, 4'b0100, 32'ha5a5_a5a5);
        bus_read(periph_pkg::REG_GPIO_DATA, data);
        exp = {data_wr[31:24], 8'ha5, pins[15:0]};
        if (data !== exp) report_mismatch("gpio data after lane 2 write", data, exp);
        repeat (4) @(negedge clk);
        exp = {exp[31:16], 16'h0};
        if (gpio_out !== exp) report_mismatch("gpio_out", gpio_out, exp);
    endtask

    task automatic test_timer();
        periph_pkg::word_t first;
        periph_pkg::word_t second;
        periph_pkg::word_t flag;
        int                polls;
        bus_write(periph_pkg::REG_TIMER_MAX, 4'hf, 32'd20);
        bus_write(periph_pkg::REG_TIMER_INTE, 4'h1, 32'd1);
        bus_write(periph_pkg::REG_TIMER_INTF, 4'h1, (32'd1 << periph_pkg::TIMER_FLAG_BIT)
                  | (32'd1 << periph_pkg::TIMER_RELOAD_BIT));
        bus_read(periph_pkg::REG_TIMER_VALUE, first);
        bus_read(periph_pkg::REG_TIMER_VALUE, second);
        if (first > 32'd20 || second >= first) begin
            $display("FAIL %0t: timer value went from %0d to %0d", $time, first, second);
            test_errors++;
        end
        polls = 0;
        flag  = '0;
        while (flag[0] !== 1'b1 && polls < IRQ_TIMEOUT) begin
            bus_read(periph_pkg::REG_TIMER_INTF, flag);
            polls++;
        end
        if (flag[0] !== 1'b1) begin
            $display("timer flag did not set within %0d reads", IRQ_TIMEOUT);
            test_errors++;
        end
        bus_write(periph_pkg::REG_TIMER_INTF, 4'h1, 32'd1 << periph_pkg::TIMER_FLAG_BIT);
        bus_read(periph_pkg::REG_TIMER_INTF, flag);
        if (flag !== '0) report_mismatch("timer flag after clear", flag, '0);
        // keep the timer quiet for the interrupt test
        bus_write(periph_pkg::REG_TIMER_INTE, 4'h1, 32'd0);
    endtask

    task automatic test_counter();
        periph_pkg::word_t low_a;
        periph_pkg::word_t low_b;
        periph_pkg::word_t high;
        periph_pkg::word_t exp;
        int                edge_a;
        bus_write(periph_pkg::REG_COUNTER_L, 4'h1, 32'd1 << periph_pkg::CNT_SAMPLE_BIT);
        edge_a = ack_edge;
        bus_read(periph_pkg::REG_COUNTER_L, low_a);
        repeat (10) @(negedge clk);
        bus_write(periph_pkg::REG_COUNTER_L, 4'h1, 32'd1 << periph_pkg::CNT_SAMPLE_BIT);
        exp = ack_edge - edge_a;
        bus_read(periph_pkg::REG_COUNTER_L, low_b);
        if (low_b - low_a !== exp) report_mismatch("sample difference", low_b - low_a, exp);
        bus_read(periph_pkg::REG_COUNTER_H, high);
        if (high !== '0) report_mismatch("counter high word", high, '0);
        bus_write(periph_pkg::REG_COUNTER_L, 4'h1, 32'd1 << periph_pkg::CNT_CLEAR_BIT);
        bus_read(periph_pkg::REG_COUNTER_L, low_a);
        if (low_a !== '0) report_mismatch("low word after clear", low_a, '0);
        bus_read(periph_pkg::REG_COUNTER_H, high);
        if (high !== '0) report_mismatch("high word after clear", high, '0);
    endtask

    task automatic test_interrupts();
        periph_pkg::word_t data;
        logic              seen;
        logic              leaked;
        // drop whatever the timer test left latched
        pulse_irq_ack();
        irq_lines[3]  = 1'b1;
        irq_lines[17] = 1'b1;
        wait_for_irq(seen);
        if (!seen) begin
            $display("cpu_irq did not rise with lines 3 and 17 active");
            test_errors++;
        end else if (irq_id !== 5'd17) begin
            report_mismatch("irq_id", {27'b0, irq_id}, 32'd17);
        end
        irq_lines[17] = 1'b0;
        pulse_irq_ack();
        wait_for_irq(seen);
        if (!seen) begin
            $display("cpu_irq did not rise again for line 3");
            test_errors++;
        end else if (irq_id !== 5'd3) begin
            report_mismatch("irq_id", {27'b0, irq_id}, 32'd3);
        end
        bus_write(periph_pkg::REG_IRQ_MASK, 4'h1, 32'd1);
        leaked = 1'b0;
        for (int i = 0; i < 5; i++) begin
            leaked = leaked | cpu_irq;
            @(negedge clk);
        end
        if (leaked) report_mismatch("cpu_irq while masked", 32'd1, '0);
        bus_read(periph_pkg::REG_IRQ_MASK, data);
        if (data !== 32'd1) report_mismatch("irq mask", data, 32'd1);
        bus_write(periph_pkg::REG_IRQ_MASK, 4'h1, 32'd0);
        if (cpu_irq !== 1'b1) report_mismatch("cpu_irq after unmask", {31'b0, cpu_irq}, 32'd1);
        irq_lines = '0;
        pulse_irq_ack();
        bus_write(periph_pkg::REG_TIMER_INTE, 4'h1, 32'd1);
        wait_for_irq(seen);
        if (!seen) begin
            $display("cpu_irq did not rise for the enabled timer flag");
            test_errors++;
        end else if (irq_id !== 5'(periph_pkg::TIMER_IRQ_ID)) begin
            report_mismatch("irq_id", {27'b0, irq_id}, periph_pkg::TIMER_IRQ_ID);
        end
        bus_write(periph_pkg::REG_TIMER_INTE, 4'h1, 32'd0);
        pulse_irq_ack();
    endtask

    initial begin
        seed         = 32'h3b0a;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_sel       = '0;
        wb_wdata     = '0;
        gpio_in      = '0;
        irq_lines    = '0;
        irq_ack      = 1'b0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_reset_values();
        finish_test("reset values");
        test_gpio();
        finish_test("gpio");
        test_timer();
        finish_test("system timer");
        test_counter();
        finish_test("cycle counter");
        test_interrupts();
        finish_test("interrupts");
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* testbench/periph_properties.sv */
`timescale 1ns/1ps

module periph_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  wb_cyc,
    input logic                  wb_stb,
    input logic                  wb_we,
    input periph_pkg::word_t     wb_adr,
    input periph_pkg::byte_sel_t wb_sel,
    input periph_pkg::word_t     wb_wdata,
    input logic                  wb_ack,
    input logic                  cpu_irq
);

    logic mask_seen;

    // global mask as last written over the bus
    always_ff @(posedge clk) begin
        if (rst) begin
            mask_seen <= 1'b0;
        end else if (wb_cyc && wb_stb && wb_we && wb_sel[0]
                     && wb_adr[5:2] == periph_pkg::REG_IRQ_MASK) begin
            mask_seen <= wb_wdata[0];
        end
    end

    // an ack only answers a strobe of the previous cycle
    ack_inside_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> wb_cyc && $past(wb_cyc && wb_stb))
        else $error("wb_ack high without wb_cyc or without a strobe one cycle earlier");

    masked_irq_low: assert property (@(posedge clk) disable iff (rst) mask_seen |-> !cpu_irq)
        else $error("cpu_irq high while the global mask is set");

    ack_follows_stb: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && wb_stb) |=> wb_ack)
        else $error("bus strobe not acknowledged in the next cycle");

endmodule

bind periph_top periph_properties props_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_sel   (wb_sel),
    .wb_wdata (wb_wdata),
    .wb_ack   (wb_ack),
    .cpu_irq  (cpu_irq)
);

/* hw/periph_top.sv */
`timescale 1ns/1ps

module periph_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  periph_pkg::word_t                   wb_adr,
    input  periph_pkg::byte_sel_t               wb_sel,
    input  periph_pkg::word_t                   wb_wdata,
    output logic                                wb_ack,
    output periph_pkg::word_t                   wb_rdata,
    input  periph_pkg::word_t                   gpio_in,
    output periph_pkg::word_t                   gpio_out,
    output periph_pkg::word_t                   gpio_dir,
    input  logic [periph_pkg::NUM_EXT_IRQ-1:0]  irq_lines,
    input  logic                                irq_ack,
    output logic                                cpu_irq,
    output periph_pkg::irq_id_t                 irq_id
);

    logic timer_irq;

    // one bus per block keeps each rdata separate
    reg_bus_if gpio_bus ();
    reg_bus_if timer_bus ();
    reg_bus_if count_bus ();
    reg_bus_if irq_bus ();

    wb_slave wb_slave_i (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_wdata  (wb_wdata),
        .wb_ack    (wb_ack),
        .wb_rdata  (wb_rdata),
        .gpio_bus  (gpio_bus),
        .timer_bus (timer_bus),
        .count_bus (count_bus),
        .irq_bus   (irq_bus)
    );

    gpio_port gpio_port_i (
        .clk      (clk),
        .rst      (rst),
        .bus      (gpio_bus),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_dir (gpio_dir)
    );

    sys_timer sys_timer_i (
        .clk       (clk),
        .rst       (rst),
        .bus       (timer_bus),
        .timer_irq (timer_irq)
    );

    cycle_counter cycle_counter_i (
        .clk (clk),
        .rst (rst),
        .bus (count_bus)
    );

    irq_ctrl irq_ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .bus       (irq_bus),
        .irq_lines (irq_lines),
        .timer_irq (timer_irq),
        .irq_ack   (irq_ack),
        .cpu_irq   (cpu_irq),
        .irq_id    (irq_id)
    );

endmodule

/* hw/irq_ctrl.sv */
`timescale 1ns/1ps

module irq_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    reg_bus_if.target                           bus,
    input  logic [periph_pkg::NUM_EXT_IRQ-1:0]  irq_lines,
    input  logic                                timer_irq,
    input  logic                                irq_ack,
    output logic                                cpu_irq,
    output periph_pkg::irq_id_t                 irq_id
);

    periph_pkg::irq_vec_t irq_vec;
    periph_pkg::irq_id_t  scan_id;
    periph_pkg::irq_id_t  latched_id;
    logic                 scan_hit;
    logic                 pending;
    logic                 irq_mask;

    assign irq_vec[periph_pkg::NUM_EXT_IRQ-1:0]   = irq_lines;
    assign irq_vec[periph_pkg::TIMER_IRQ_ID]      = timer_irq;

    // highest numbered active source
    always_comb begin
        scan_id  = '0;
        scan_hit = 1'b0;
        for (int i = 0; i < periph_pkg::NUM_IRQ; i++) begin
            if (irq_vec[i]) begin
                scan_id  = periph_pkg::irq_id_t'(i);
                scan_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending    <= 1'b0;
            latched_id <= '0;
            irq_mask   <= 1'b0;
        end else begin
            if (irq_ack) begin
                pending <= 1'b0;
            end else if (!pending && scan_hit) begin
                pending    <= 1'b1;
                latched_id <= scan_id;
            end
            if (bus.wr && bus.sel[0] && bus.idx == periph_pkg::REG_IRQ_MASK) begin
                irq_mask <= bus.wdata[0];
            end
        end
    end

    // request drops if the latched source goes away
    assign cpu_irq = pending & ~irq_mask & irq_vec[latched_id];
    assign irq_id  = latched_id;

    always_comb begin
        bus.rdata = '0;
        if (bus.rd && bus.idx == periph_pkg::REG_IRQ_MASK) begin
            bus.rdata = {31'b0, irq_mask};
        end
    end

endmodule

/* timer/cycle_counter.sv */
`timescale 1ns/1ps

module cycle_counter (
    input  logic      clk,
    input  logic      rst,
    reg_bus_if.target bus
);

    periph_pkg::count64_t count;
    periph_pkg::count64_t count_smp;
    logic                 ctrl_wr;

    assign ctrl_wr = bus.wr && bus.sel[0] && bus.idx == periph_pkg::REG_COUNTER_L;

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            count_smp <= '0;
        end else begin
            count <= count + 1'b1;
            if (ctrl_wr) begin
                // clear wins over sample
                if (bus.wdata[periph_pkg::CNT_CLEAR_BIT]) begin
                    count     <= '0;
                    count_smp <= '0;
                end else if (bus.wdata[periph_pkg::CNT_SAMPLE_BIT]) begin
                    count_smp <= count;
                end
            end
        end
    end

    // software reads the sampled copy only
    always_comb begin
        bus.rdata = '0;
        if (bus.rd) begin
            case (bus.idx)
                periph_pkg::REG_COUNTER_L: bus.rdata = count_smp[31:0];
                periph_pkg::REG_COUNTER_H: bus.rdata = count_smp[63:32];
                default:                   bus.rdata = '0;
            endcase
        end
    end

endmodule

/* timer/sys_timer.sv */
`timescale 1ns/1ps

module sys_timer (
    input  logic      clk,
    input  logic      rst,
    reg_bus_if.target bus,
    output logic      timer_irq
);

    periph_pkg::word_t timer_max;
    periph_pkg::word_t timer_value;
    logic              timer_flag;
    logic              timer_inte;
    logic              lane0_wr;

    // single-bit controls live in byte lane 0
    assign lane0_wr = bus.wr & bus.sel[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            timer_max   <= '0;
            timer_value <= '0;
            timer_flag  <= 1'b0;
            timer_inte  <= 1'b0;
        end else begin
            // reload and flag on the zero cycle
            if (timer_value == '0) begin
                timer_value <= timer_max;
                timer_flag  <= 1'b1;
            end else begin
                timer_value <= timer_value - 1'b1;
            end

            if (lane0_wr && bus.idx == periph_pkg::REG_TIMER_INTE) begin
                timer_inte <= bus.wdata[0];
            end
            if (lane0_wr && bus.idx == periph_pkg::REG_TIMER_INTF) begin
                // write 1 to clear flag
                if (bus.wdata[periph_pkg::TIMER_FLAG_BIT]) begin
                    timer_flag <= 1'b0;
                end
                if (bus.wdata[periph_pkg::TIMER_RELOAD_BIT]) begin
                    timer_value <= timer_max;
                end
            end
            if (bus.wr && bus.idx == periph_pkg::REG_TIMER_MAX) begin
                timer_max <= periph_pkg::merge_bytes(timer_max, bus.wdata, bus.sel);
            end
        end
    end

    assign timer_irq = timer_flag & timer_inte;

    always_comb begin
        bus.rdata = '0;
        if (bus.rd) begin
            case (bus.idx)
                periph_pkg::REG_TIMER_INTE:  bus.rdata = {31'b0, timer_inte};
                periph_pkg::REG_TIMER_INTF:  bus.rdata = {31'b0, timer_flag};
                periph_pkg::REG_TIMER_VALUE: bus.rdata = timer_value;
                periph_pkg::REG_TIMER_MAX:   bus.rdata = timer_max;
                default:                     bus.rdata = '0;
            endcase
        end
    end

endmodule

/* gpio/gpio_port.sv */
`timescale 1ns/1ps

module gpio_port (
    input  logic              clk,
    input  logic              rst,
    reg_bus_if.target         bus,
    input  periph_pkg::word_t gpio_in,
    output periph_pkg::word_t gpio_out,
    output periph_pkg::word_t gpio_dir
);

    periph_pkg::word_t gpio_data;
    // 1 = input pin
    periph_pkg::word_t gpio_ddr;
    periph_pkg::word_t in_sync;
    periph_pkg::word_t out_pipe;
    periph_pkg::word_t dir_pipe;

    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_data <= '0;
            gpio_ddr  <= '1;
            in_sync   <= '0;
            out_pipe  <= '0;
            dir_pipe  <= '1;
            gpio_out  <= '0;
            gpio_dir  <= '1;
        end else begin
            in_sync  <= gpio_in;
            out_pipe <= gpio_data;
            dir_pipe <= gpio_ddr;
            gpio_dir <= dir_pipe;
            // data reg doubles as second sync stage for input pins
            for (int i = 0; i < periph_pkg::DATA_W; i++) begin
                if (gpio_ddr[i]) begin
                    gpio_data[i] <= in_sync[i];
                end else begin
                    gpio_out[i] <= out_pipe[i];
                end
            end
            if (bus.wr && bus.idx == periph_pkg::REG_GPIO_DATA) begin
                gpio_data <= periph_pkg::merge_bytes(gpio_data, bus.wdata, bus.sel);
            end
            if (bus.wr && bus.idx == periph_pkg::REG_GPIO_DIR) begin
                gpio_ddr <= periph_pkg::merge_bytes(gpio_ddr, bus.wdata, bus.sel);
            end
        end
    end

    ////////////////////////////////////////
    // read back
    ////////////////////////////////////////

    always_comb begin
        bus.rdata = '0;
        if (bus.rd) begin
            case (bus.idx)
                periph_pkg::REG_GPIO_DATA: bus.rdata = gpio_data;
                periph_pkg::REG_GPIO_DIR:  bus.rdata = gpio_ddr;
                default:                   bus.rdata = '0;
            endcase
        end
    end

endmodule

/* hw/wb_slave.sv */
`timescale 1ns/1ps

module wb_slave (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  periph_pkg::word_t     wb_adr,
    input  periph_pkg::byte_sel_t wb_sel,
    input  periph_pkg::word_t     wb_wdata,
    output logic                  wb_ack,
    output periph_pkg::word_t     wb_rdata,
    reg_bus_if.master             gpio_bus,
    reg_bus_if.master             timer_bus,
    reg_bus_if.master             count_bus,
    reg_bus_if.master             irq_bus
);

    logic                 wr;
    logic                 rd;
    logic                 ack_q;
    periph_pkg::reg_idx_t idx;
    periph_pkg::word_t    rdata_q;

    assign wr  = wb_cyc & wb_stb & wb_we;
    assign rd  = wb_cyc & wb_stb & ~wb_we;
    assign idx = wb_adr[5:2];

    // same strobes go to every block
    assign gpio_bus.wr     = wr;
    assign gpio_bus.rd     = rd;
    assign gpio_bus.idx    = idx;
    assign gpio_bus.wdata  = wb_wdata;
    assign gpio_bus.sel    = wb_sel;
    assign timer_bus.wr    = wr;
    assign timer_bus.rd    = rd;
    assign timer_bus.idx   = idx;
    assign timer_bus.wdata = wb_wdata;
    assign timer_bus.sel   = wb_sel;
    assign count_bus.wr    = wr;
    assign count_bus.rd    = rd;
    assign count_bus.idx   = idx;
    assign count_bus.wdata = wb_wdata;
    assign count_bus.sel   = wb_sel;
    assign irq_bus.wr      = wr;
    assign irq_bus.rd      = rd;
    assign irq_bus.idx     = idx;
    assign irq_bus.wdata   = wb_wdata;
    assign irq_bus.sel     = wb_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_cyc & wb_stb;
        end
    end

    // unowned index gives zero from every block
    always_ff @(posedge clk) begin
        rdata_q <= gpio_bus.rdata | timer_bus.rdata | count_bus.rdata | irq_bus.rdata;
    end

    // ack drops as soon as the master leaves the cycle
    assign wb_ack   = wb_cyc & ack_q;
    assign wb_rdata = rdata_q;

endmodule

/* common/reg_bus_if.sv */
`timescale 1ns/1ps

// register access between the bus slave and one register block
interface reg_bus_if;

    logic                 wr;
    logic                 rd;
    periph_pkg::reg_idx_t  idx;
    periph_pkg::word_t     wdata;
    periph_pkg::byte_sel_t sel;
    // zero unless this block owns idx during rd
    periph_pkg::word_t     rdata;

    modport master (
        output wr,
        output rd,
        output idx,
        output wdata,
        output sel,
        input  rdata
    );

    modport target (
        input  wr,
        input  rd,
        input  idx,
        input  wdata,
        input  sel,
        output rdata
    );

endinterface

/* common/periph_pkg.sv */
package periph_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int DATA_W       = 32;
    localparam int REG_IDX_W    = 4;
    localparam int NUM_EXT_IRQ  = 29;
    localparam int NUM_IRQ      = NUM_EXT_IRQ + 1;
    localparam int TIMER_IRQ_ID = 29;
    localparam int IRQ_ID_W     = 5;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [DATA_W/8-1:0]   byte_sel_t;
    typedef logic [NUM_IRQ-1:0]    irq_vec_t;
    typedef logic [IRQ_ID_W-1:0]   irq_id_t;
    typedef logic [2*DATA_W-1:0]   count64_t;

    ////////////////////////////////////////
    // register map, word index from adr[5:2]
    ////////////////////////////////////////

    localparam reg_idx_t REG_GPIO_DATA   = 4'd0;
    localparam reg_idx_t REG_GPIO_DIR    = 4'd1;
    localparam reg_idx_t REG_COUNTER_L   = 4'd2;
    localparam reg_idx_t REG_COUNTER_H   = 4'd3;
    localparam reg_idx_t REG_IRQ_MASK    = 4'd4;
    localparam reg_idx_t REG_TIMER_INTE  = 4'd5;
    localparam reg_idx_t REG_TIMER_INTF  = 4'd6;
    localparam reg_idx_t REG_TIMER_VALUE = 4'd7;
    localparam reg_idx_t REG_TIMER_MAX   = 4'd8;

    // control bits in REG_COUNTER_L writes
    localparam int CNT_CLEAR_BIT  = 0;
    localparam int CNT_SAMPLE_BIT = 1;

    // control bits in REG_TIMER_INTF writes
    localparam int TIMER_FLAG_BIT   = 0;
    localparam int TIMER_RELOAD_BIT = 1;

    // byte lane merge for wide writable registers
    function automatic word_t merge_bytes(input word_t old_val, input word_t new_val,
                                          input byte_sel_t sel);
        word_t result;
        result = old_val;
        for (int b = 0; b < DATA_W / 8; b++) begin
            if (sel[b]) begin
                result[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage
